/* run.sh */
#!/bin/sh
# Build and run the vector memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module vmem_tb -o vmem_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/vmem_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error"
    cat sim.log
    exit 1
fi

cat sim.log
if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
exit 1

/* source/vmem_addr_gen.sv */
// Lane address generator
// Address and store word for the current lane, plus alignment check
`timescale 1ns/1ps

module vmem_addr_gen #(
    parameter int NUM_LANES = 4
) (
    input  vmem_pkg::mem_req_t            req,
    input  logic [$clog2(NUM_LANES)-1:0]  lane,
    input  logic [NUM_LANES-1:0][31:0]    lane_store_data,
    output logic [31:0]                   addr,
    output logic [31:0]                   store_data,
    output logic                          misaligned
);

    import vmem_pkg::*;

    logic [31:0] lane_idx;

    assign lane_idx = 32'(lane);

    always_comb begin
        case (req.op)
            OP_VLE, OP_VSE:   addr = req.base + (lane_idx << 2);
            OP_VLSE, OP_VSSE: addr = req.base + req.stride * lane_idx;
            default:          addr = req.base;
        endcase

        case (access_size(req.op))
            2'd0:    misaligned = 1'b0;
            2'd1:    misaligned = addr[0];
            default: misaligned = |addr[1:0];
        endcase
    end

    // Scalar ops always sit on lane 0
    assign store_data = lane_store_data[lane];

endmodule

/* source/vmem_bus_port.sv */
// Wishbone classic data master
// One transfer per start, byte lane steering and load extension
`timescale 1ns/1ps

module vmem_bus_port (
    input  logic              CLK,
    input  logic              rst,
    input  logic              start,
    input  vmem_pkg::mem_op_e op,
    input  logic [31:0]       addr,
    input  logic [31:0]       store_data,
    output logic              cyc,
    output logic              stb,
    output logic              we,
    output logic [31:0]       adr,
    output logic [31:0]       dat_w,
    output logic [3:0]        sel,
    input  logic [31:0]       dat_r,
    input  logic              ack,
    input  logic              err,
    output logic              done,
    output logic              error,
    output logic [31:0]       load_data
);

    import vmem_pkg::*;

    mem_op_e     op_q;
    logic [1:0]  off_q;
    logic [7:0]  byte_v;
    logic [15:0] half_v;

    // Cycle held until the slave answers
    always_ff @(posedge CLK) begin
        if (rst) begin
            cyc <= 1'b0;
        end else if (start) begin
            cyc <= 1'b1;
        end else if (cyc && (ack || err)) begin
            cyc <= 1'b0;
        end
    end

    assign stb = cyc;

    always_ff @(posedge CLK) begin
        if (start) begin
            op_q  <= op;
            off_q <= addr[1:0];
            we    <= is_store(op);
            adr   <= {addr[31:2], 2'b00};
            case (access_size(op))
                2'd0: begin
                    dat_w <= {4{store_data[7:0]}};
                    sel   <= 4'b0001 << addr[1:0];
                end
                2'd1: begin
                    dat_w <= {2{store_data[15:0]}};
                    sel   <= addr[1] ? 4'b1100 : 4'b0011;
                end
                default: begin
                    dat_w <= store_data;
                    sel   <= 4'b1111;
                end
            endcase
        end
    end

    assign done  = cyc && ack;
    assign error = cyc && err;

    // Pick the addressed byte or half and extend it
    always_comb begin
        byte_v = dat_r[8*off_q +: 8];
        half_v = dat_r[16*off_q[1] +: 16];
        case (op_q)
            OP_LB:   load_data = {{24{byte_v[7]}}, byte_v};
            OP_LBU:  load_data = {24'b0, byte_v};
            OP_LH:   load_data = {{16{half_v[15]}}, half_v};
            OP_LHU:  load_data = {16'b0, half_v};
            default: load_data = dat_r;
        endcase
    end

    // Slave must only respond inside a cycle
    assert property (@(posedge CLK) disable iff (rst) (ack || err) |-> cyc)
        else $error("vmem_bus_port: ack/err outside of a bus cycle");

endmodule

/* source/vmem_ctrl.sv */
// Memory stage control FSM
// Walks the active lanes one bus cycle at a time and reports the outcome
`timescale 1ns/1ps

module vmem_ctrl #(
    parameter int NUM_LANES = 4
) (
    input  logic                          CLK,
    input  logic                          rst,
    input  logic                          req_valid,
    input  vmem_pkg::mem_req_t            req,
    input  logic [NUM_LANES-1:0]          active_mask,
    input  logic [31:0]                   addr,
    input  logic                          misaligned,
    input  logic                          bus_done,
    input  logic                          bus_error,
    input  logic [31:0]                   load_data,
    output logic                          ready,
    output vmem_pkg::mem_req_t            req_q,
    output logic [$clog2(NUM_LANES)-1:0]  lane,
    output logic                          bus_start,
    output vmem_pkg::scalar_wb_t          scalar_wb,
    output logic                          elem_wen,
    output vmem_pkg::result_t             result
);

    import vmem_pkg::*;

    localparam int LANE_W = $clog2(NUM_LANES);

    ctrl_state_e          state;
    logic [NUM_LANES-1:0] pend;
    fault_e               fault_q;
    logic [31:0]          fault_addr_q;
    logic                 accept;
    logic                 load_ack;

    assign ready  = (state == S_IDLE);
    assign accept = req_valid && ready;

    // Lowest lane still pending
    always_comb begin
        lane = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (pend[i]) begin
                lane = LANE_W'(i);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state   <= S_IDLE;
            pend    <= '0;
            fault_q <= F_NONE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state   <= S_SCAN;
                        fault_q <= F_NONE;
                        pend    <= is_vector(req.op) ? active_mask : NUM_LANES'(1);
                    end
                end
                S_SCAN: begin
                    if (pend == '0) begin
                        state <= S_DONE;
                    end else if (misaligned) begin
                        fault_q <= is_store(req_q.op) ? F_MAL_STORE : F_MAL_LOAD;
                        state   <= S_DONE;
                    end else begin
                        state <= S_BUS;
                    end
                end
                S_BUS: begin
                    if (bus_error) begin
                        fault_q <= F_BUS;
                        state   <= S_DONE;
                    end else if (bus_done) begin
                        pend[lane] <= 1'b0;
                        state      <= S_SCAN;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            req_q        <= req;
            fault_addr_q <= 32'b0;
        end else if ((state == S_SCAN && pend != '0 && misaligned) ||
                     (state == S_BUS && bus_error)) begin
            fault_addr_q <= addr;
        end
    end

    assign bus_start = (state == S_SCAN) && (pend != '0) && !misaligned;

    assign load_ack = (state == S_BUS) && bus_done && !bus_error && !is_store(req_q.op);
    assign elem_wen = load_ack && is_vector(req_q.op);

    assign scalar_wb.valid = load_ack && !is_vector(req_q.op);
    assign scalar_wb.rd    = req_q.rd;
    assign scalar_wb.data  = load_data;

    assign result.done       = (state == S_DONE);
    assign result.fault      = fault_q;
    assign result.fault_addr = fault_addr_q;

    // Bus port answers only while the FSM waits for it
    assert property (@(posedge CLK) disable iff (rst) (bus_done || bus_error) |-> state == S_BUS)
        else $error("vmem_ctrl: bus response outside S_BUS");

endmodule

/* source/vmem_elem_mask.sv */
// Effective element mask
// Drops every lane below vstart, the rest follow the lane mask
`timescale 1ns/1ps

module vmem_elem_mask #(
    parameter int NUM_LANES = 4
) (
    input  logic [NUM_LANES-1:0] lane_mask,
    input  logic [1:0]           vstart,
    output logic [NUM_LANES-1:0] active_mask
);

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            // Lanes before vstart already completed
            active_mask[i] = lane_mask[i] && (i >= int'(vstart));
        end
    end

endmodule

/* source/vmem_pkg.sv */
// Vector memory stage definitions
// Opcodes, control states, fault causes and the request/result records
package vmem_pkg;

    typedef enum logic [3:0] {
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_VLE,
        OP_VLSE,
        OP_VSE,
        OP_VSSE
    } mem_op_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SCAN,
        S_BUS,
        S_DONE
    } ctrl_state_e;

    typedef enum logic [1:0] {
        F_NONE,
        F_MAL_LOAD,
        F_MAL_STORE,
        F_BUS
    } fault_e;

    // Scalar store data travels in lane 0 of the store-data array
    typedef struct packed {
        mem_op_e     op;
        logic [4:0]  rd;
        logic [31:0] base;
        logic [31:0] stride;
        logic [1:0]  vstart;
        logic [1:0]  bank_offset;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } scalar_wb_t;

    typedef struct packed {
        logic        done;
        fault_e      fault;
        logic [31:0] fault_addr;
    } result_t;

    function automatic logic is_vector(mem_op_e op);
        return op inside {OP_VLE, OP_VLSE, OP_VSE, OP_VSSE};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW, OP_VSE, OP_VSSE};
    endfunction

    // 0 byte, 1 half, 2 word
    function automatic logic [1:0] access_size(mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 2'd0;
            OP_LH, OP_LHU, OP_SH: return 2'd1;
            default:              return 2'd2;
        endcase
    endfunction

endpackage

/* source/vmem_stage.sv */
// Vector memory stage top
// Control FSM, lane masking, address generation, bus master and bank crossbar
`timescale 1ns/1ps

module vmem_stage #(
    parameter int NUM_LANES = 4
) (
    input  logic                        CLK,
    input  logic                        rst,
    input  logic                        req_valid,
    input  vmem_pkg::mem_req_t          req,
    input  logic [NUM_LANES-1:0]        lane_mask,
    input  logic [NUM_LANES-1:0][31:0]  lane_store_data,
    output logic                        ready,
    output logic                        cyc,
    output logic                        stb,
    output logic                        we,
    output logic [31:0]                 adr,
    output logic [31:0]                 dat_w,
    output logic [3:0]                  sel,
    input  logic [31:0]                 dat_r,
    input  logic                        ack,
    input  logic                        err,
    output vmem_pkg::scalar_wb_t        scalar_wb,
    output logic [NUM_LANES-1:0][31:0]  bank_wdata,
    output logic [NUM_LANES-1:0]        bank_wen,
    output vmem_pkg::result_t           result
);

    import vmem_pkg::*;

    mem_req_t                   req_q;
    logic [NUM_LANES-1:0]       active_mask;
    logic [NUM_LANES-1:0][31:0] store_q;
    logic [$clog2(NUM_LANES)-1:0] lane;
    logic [31:0]                addr;
    logic [31:0]                store_data;
    logic [31:0]                load_data;
    logic                       misaligned;
    logic                       bus_start;
    logic                       bus_done;
    logic                       bus_error;
    logic                       elem_wen;

    // Store words captured with the request
    always_ff @(posedge CLK) begin
        if (req_valid && ready) begin
            store_q <= lane_store_data;
        end
    end

    vmem_elem_mask #(.NUM_LANES(NUM_LANES)) u_mask (
        .lane_mask  (lane_mask),
        .vstart     (req.vstart),
        .active_mask(active_mask)
    );

    vmem_ctrl #(.NUM_LANES(NUM_LANES)) u_ctrl (
        .CLK, .rst, .req_valid, .req, .active_mask, .addr, .misaligned,
        .bus_done, .bus_error, .load_data, .ready, .req_q, .lane,
        .bus_start, .scalar_wb, .elem_wen, .result
    );

    vmem_addr_gen #(.NUM_LANES(NUM_LANES)) u_addr (
        .req            (req_q),
        .lane           (lane),
        .lane_store_data(store_q),
        .addr           (addr),
        .store_data     (store_data),
        .misaligned     (misaligned)
    );

    vmem_bus_port u_bus (
        .CLK, .rst, .start(bus_start), .op(req_q.op), .addr, .store_data,
        .cyc, .stb, .we, .adr, .dat_w, .sel, .dat_r, .ack, .err,
        .done(bus_done), .error(bus_error), .load_data
    );

    vmem_write_xbar #(.NUM_LANES(NUM_LANES)) u_xbar (
        .lane       (lane),
        .bank_offset(req_q.bank_offset),
        .wdata      (load_data),
        .wen        (elem_wen),
        .bank_wdata (bank_wdata),
        .bank_wen   (bank_wen)
    );

    // 2-bit vstart and bank_offset cover at most four lanes
    initial begin
        assert (NUM_LANES >= 2 && NUM_LANES <= 4 && (NUM_LANES & (NUM_LANES - 1)) == 0)
            else $error("vmem_stage: NUM_LANES must be 2 or 4");
    end

endmodule

/* source/vmem_write_xbar.sv */
// Register bank write crossbar
// Sends one lane's element to bank (lane + bank_offset) mod NUM_LANES
`timescale 1ns/1ps

module vmem_write_xbar #(
    parameter int NUM_LANES = 4
) (
    input  logic [$clog2(NUM_LANES)-1:0] lane,
    input  logic [1:0]                   bank_offset,
    input  logic [31:0]                  wdata,
    input  logic                         wen,
    output logic [NUM_LANES-1:0][31:0]   bank_wdata,
    output logic [NUM_LANES-1:0]         bank_wen
);

    localparam int LANE_W = $clog2(NUM_LANES);

    logic [LANE_W-1:0] bank;

    // Truncation gives the modulo for a power of two
    assign bank = LANE_W'(lane + bank_offset);

    always_comb begin
        for (int b = 0; b < NUM_LANES; b++) begin
            bank_wen[b]   = wen && (bank == LANE_W'(b));
            bank_wdata[b] = (bank == LANE_W'(b)) ? wdata : 32'b0;
        end
    end

endmodule

/* tb.f */
source/vmem_pkg.sv
source/vmem_elem_mask.sv
source/vmem_addr_gen.sv
source/vmem_bus_port.sv
source/vmem_write_xbar.sv
source/vmem_ctrl.sv
source/vmem_stage.sv
verification/vmem_checker.sv
verification/vmem_tb.sv

/* verification/vmem_checker.sv */
// Result checker for the vector memory stage
// Collects bank writes, scalar writeback and bus transfers per operation
// and compares them with the expected values when done is seen
`timescale 1ns/1ps

module vmem_checker #(
    parameter int NUM_LANES = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid,
    input  logic                       ready,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic                       ack,
    input  logic                       err,
    input  vmem_pkg::scalar_wb_t       scalar_wb,
    input  logic [NUM_LANES-1:0][31:0] bank_wdata,
    input  logic [NUM_LANES-1:0]       bank_wen,
    input  vmem_pkg::result_t          result,
    input  int                         test_id,
    input  int                         exp_cycles,
    input  logic                       exp_we,
    input  logic [NUM_LANES-1:0]       exp_wen,
    input  logic [NUM_LANES-1:0][31:0] exp_bank,
    input  logic                       exp_sv,
    input  logic [4:0]                 exp_rd,
    input  logic [31:0]                exp_sdata,
    input  vmem_pkg::fault_e           exp_fault,
    input  logic [31:0]                exp_fault_addr,
    output int                         checked,
    output int                         errors
);

    import vmem_pkg::*;

    logic                       busy;
    logic                       rst_d;
    logic                       dup;
    logic                       got_sv;
    logic [4:0]                 got_rd;
    logic [31:0]                got_sdata;
    logic [NUM_LANES-1:0]       got_wen;
    logic [NUM_LANES-1:0][31:0] got_bank;
    int                         lat;
    int                         cycles;

    initial begin
        busy    = 1'b0;
        rst_d   = 1'b1;
        checked = 0;
        errors  = 0;
    end

    always @(posedge clk) begin
        int bad;
        bad = 0;
        // Idle outputs right after reset release
        if (rst_d && !rst) begin
            if (cyc || stb || scalar_wb.valid || bank_wen != '0 || result.done || !ready) begin
                $display("test reset: outputs not in their idle state after reset");
                errors = errors + 1;
            end else begin
                $display("test reset ok");
            end
            checked = checked + 1;
        end
        rst_d = rst;

        if (busy) begin
            lat = lat + 1;
            if (ready) begin
                $display("test %0d: ready high while the operation is in flight", test_id);
                bad = bad + 1;
            end
            if (cyc && (ack || err)) begin
                cycles = cycles + 1;
                if (we != exp_we) begin
                    $display("ERR test %0d we got %h exp %h", test_id, we, exp_we);
                    bad = bad + 1;
                end
            end
            for (int b = 0; b < NUM_LANES; b++) begin
                if (bank_wen[b]) begin
                    if (got_wen[b]) begin
                        dup = 1'b1;
                    end
                    got_wen[b]  = 1'b1;
                    got_bank[b] = bank_wdata[b];
                end
            end
            if (scalar_wb.valid) begin
                got_sv    = 1'b1;
                got_rd    = scalar_wb.rd;
                got_sdata = scalar_wb.data;
            end
            if (result.done) begin
                if (cycles != exp_cycles) begin
                    $display("ERR test %0d bus_cycles got %h exp %h", test_id, cycles, exp_cycles);
                    bad = bad + 1;
                end
                if (exp_cycles == 0 && lat != 2) begin
                    $display("test %0d: done came %0d cycles after acceptance, not 2",
                             test_id, lat);
                    bad = bad + 1;
                end
                if (dup) begin
                    $display("test %0d: a bank was written more than once", test_id);
                    bad = bad + 1;
                end
                if (got_wen != exp_wen) begin
                    $display("ERR test %0d bank_wen got %h exp %h", test_id, got_wen, exp_wen);
                    bad = bad + 1;
                end
                for (int b = 0; b < NUM_LANES; b++) begin
                    if (exp_wen[b] && got_wen[b] && got_bank[b] != exp_bank[b]) begin
                        $display("ERR test %0d bank_wdata[%0d] got %h exp %h",
                                 test_id, b, got_bank[b], exp_bank[b]);
                        bad = bad + 1;
                    end
                end
                if (got_sv != exp_sv) begin
                    $display("ERR test %0d scalar_wb.valid got %h exp %h", test_id, got_sv, exp_sv);
                    bad = bad + 1;
                end else if (exp_sv && (got_sdata != exp_sdata || got_rd != exp_rd)) begin
                    $display("ERR test %0d scalar_wb.data got %h exp %h (rd %h exp %h)",
                             test_id, got_sdata, exp_sdata, got_rd, exp_rd);
                    bad = bad + 1;
                end
                if (result.fault != exp_fault || result.fault_addr != exp_fault_addr) begin
                    $display("ERR test %0d result.fault got %h/%h exp %h/%h", test_id,
                             result.fault, result.fault_addr, exp_fault, exp_fault_addr);
                    bad = bad + 1;
                end
                if (bad == 0) begin
                    $display("test %0d ok", test_id);
                end
                busy    = 1'b0;
                checked = checked + 1;
            end
            errors = errors + bad;
        end else if (!rst && req_valid && ready) begin
            busy    = 1'b1;
            dup     = 1'b0;
            lat     = 0;
            cycles  = 0;
            got_wen = '0;
            got_sv  = 1'b0;
        end
    end

endmodule

/* verification/vmem_tb.sv */
// Testbench for the vector memory stage
// Stimulus table, reference memory and a Wishbone slave with random ack delay
`timescale 1ns/1ps

module vmem_tb;

    import vmem_pkg::*;

    localparam int LANES = 4;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] base;
        logic [31:0] stride;
        logic [3:0]  mask;
        logic [1:0]  vstart;
        logic [1:0]  boff;
        logic [31:0] sdata;
        logic        err_en;
        logic [31:0] err_addr;
        fault_e      fault;
    } test_t;

    logic                   clk;
    logic                   rst;
    logic                   req_valid;
    mem_req_t               req;
    logic [LANES-1:0]       lane_mask;
    logic [LANES-1:0][31:0] lane_store_data;
    logic                   ready;
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [31:0]            adr;
    logic [31:0]            dat_w;
    logic [3:0]             sel;
    logic [31:0]            dat_r;
    logic                   ack;
    logic                   err;
    scalar_wb_t             scalar_wb;
    logic [LANES-1:0][31:0] bank_wdata;
    logic [LANES-1:0]       bank_wen;
    result_t                result;

    int                     test_id;
    int                     exp_cycles;
    logic                   exp_we;
    logic [LANES-1:0]       exp_wen;
    logic [LANES-1:0][31:0] exp_bank;
    logic                   exp_sv;
    logic [4:0]             exp_rd;
    logic [31:0]            exp_sdata;
    fault_e                 exp_fault;
    logic [31:0]            exp_fault_addr;
    int                     checked;
    int                     errors;

    test_t       tests[$];
    test_t       cur;
    logic [31:0] mem[64];
    logic [31:0] ref_mem[64];
    logic [31:0] rng;
    logic        pending;
    int          wait_cnt;

    vmem_stage #(.NUM_LANES(LANES)) dut0 (
        .CLK(clk), .rst, .req_valid, .req, .lane_mask, .lane_store_data, .ready,
        .cyc, .stb, .we, .adr, .dat_w, .sel, .dat_r, .ack, .err,
        .scalar_wb, .bank_wdata, .bank_wen, .result
    );

    vmem_checker #(.NUM_LANES(LANES)) chk0 (
        .clk, .rst, .req_valid, .ready, .cyc, .stb, .we, .ack, .err, .scalar_wb,
        .bank_wdata, .bank_wen, .result, .test_id, .exp_cycles, .exp_we, .exp_wen,
        .exp_bank, .exp_sv, .exp_rd, .exp_sdata, .exp_fault, .exp_fault_addr,
        .checked, .errors
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] fill_word(int idx);
        logic [31:0] a;
        a = 32'(idx) << 2;
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic vector_op(mem_op_e op);
        return op == OP_VLE || op == OP_VLSE || op == OP_VSE || op == OP_VSSE;
    endfunction

    function automatic logic store_op(mem_op_e op);
        return op == OP_SB || op == OP_SH || op == OP_SW || op == OP_VSE || op == OP_VSSE;
    endfunction

    function automatic int bytes_of(mem_op_e op);
        if (op == OP_LB || op == OP_LBU || op == OP_SB) return 1;
        if (op == OP_LH || op == OP_LHU || op == OP_SH) return 2;
        return 4;
    endfunction

    // RV32 load extension of the addressed byte or half
    function automatic logic [31:0] load_value(mem_op_e op, logic [31:0] w, logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (op)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'b0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'b0, h};
            default: return w;
        endcase
    endfunction

    task automatic add(mem_op_e op, logic [31:0] base, logic [31:0] stride, logic [3:0] mask,
                       logic [1:0] vstart, logic [1:0] boff, logic [31:0] sdata,
                       logic err_en, logic [31:0] err_addr, fault_e fault);
        test_t t;
        t = '{op, base, stride, mask, vstart, boff, sdata, err_en, err_addr, fault};
        tests.push_back(t);
    endtask

    // Walks the lanes by the stage's rules and updates the reference memory
    task automatic compute_expect(test_t t, int id);
        logic [31:0] a;
        logic [31:0] sd;
        logic [31:0] w;
        logic        stop;
        logic        act;
        int          sz;
        int          bank;
        exp_cycles     = 0;
        exp_we         = store_op(t.op);
        exp_wen        = '0;
        exp_bank       = '0;
        exp_sv         = 1'b0;
        exp_rd         = 5'(id + 1);
        exp_sdata      = 32'b0;
        exp_fault      = t.fault;
        exp_fault_addr = 32'b0;
        stop           = 1'b0;
        sz             = bytes_of(t.op);
        for (int l = 0; l < LANES; l++) begin
            act = vector_op(t.op) ? (t.mask[l] && l >= int'(t.vstart)) : (l == 0);
            if (act && !stop) begin
                case (t.op)
                    OP_VLE, OP_VSE:   a = t.base + 32'(4 * l);
                    OP_VLSE, OP_VSSE: a = t.base + t.stride * 32'(l);
                    default:          a = t.base;
                endcase
                sd = t.sdata ^ (32'h1111_1111 * 32'(l));
                w  = ref_mem[a[7:2]];
                if ((a % 32'(sz)) != 0) begin
                    stop           = 1'b1;
                    exp_fault_addr = a;
                end else begin
                    exp_cycles = exp_cycles + 1;
                    if (t.err_en && a[31:2] == t.err_addr[31:2]) begin
                        stop           = 1'b1;
                        exp_fault_addr = a;
                    end else if (store_op(t.op)) begin
                        if (sz == 1) w[8*a[1:0] +: 8] = sd[7:0];
                        else if (sz == 2) w[16*a[1] +: 16] = sd[15:0];
                        else w = sd;
                        ref_mem[a[7:2]] = w;
                    end else if (vector_op(t.op)) begin
                        bank           = (l + int'(t.boff)) % LANES;
                        exp_wen[bank]  = 1'b1;
                        exp_bank[bank] = w;
                    end else begin
                        exp_sv    = 1'b1;
                        exp_sdata = load_value(t.op, w, a[1:0]);
                    end
                end
            end
        end
    endtask

    // Wishbone slave, answers after 0 to 3 cycles
    always @(negedge clk) begin
        if (ack || err) begin
            ack     = 1'b0;
            err     = 1'b0;
            pending = 1'b0;
        end else if (cyc && stb) begin
            if (!pending) begin
                pending  = 1'b1;
                rng      = xorshift(rng);
                wait_cnt = int'(rng[1:0]);
            end
            if (wait_cnt == 0) begin
                if (cur.err_en && adr[31:2] == cur.err_addr[31:2]) begin
                    err = 1'b1;
                end else begin
                    ack   = 1'b1;
                    dat_r = mem[adr[7:2]];
                    if (we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (sel[b]) mem[adr[7:2]][8*b +: 8] = dat_w[8*b +: 8];
                        end
                    end
                end
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $finish;
    endtask

    initial begin
        int n;
        rst             = 1'b1;
        req_valid       = 1'b0;
        req             = '0;
        lane_mask       = '0;
        lane_store_data = '0;
        dat_r           = 32'b0;
        ack             = 1'b0;
        err             = 1'b0;
        pending         = 1'b0;
        wait_cnt        = 0;
        rng             = 32'h812f_baf8;
        test_id         = 0;
        cur             = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i]     = fill_word(i);
            ref_mem[i] = fill_word(i);
        end

        // Scalar loads at each legal offset
        add(OP_LB, 32'h10, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        add(OP_LB, 32'h11, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        add(OP_LB, 32'h12, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        add(OP_LB, 32'h13, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        add(OP_LBU, 32'h10, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        add(OP_LBU, 32'h11, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        add(OP_LBU, 32'h12, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        add(OP_LBU, 32'h13, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        add(OP_LH, 32'h14, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        add(OP_LH, 32'h16, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        add(OP_LHU, 32'h14, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        add(OP_LHU, 32'h16, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        add(OP_LW, 32'h18, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        // Scalar stores read back as words
        add(OP_SB, 32'h21, 0, 4'hf, 0, 0, 32'h0000_00ab, 0, 0, F_NONE);
        add(OP_SH, 32'h26, 0, 4'hf, 0, 0, 32'h0000_beef, 0, 0, F_NONE);
        add(OP_SW, 32'h28, 0, 4'hf, 0, 0, 32'h1234_5678, 0, 0, F_NONE);
        add(OP_LW, 32'h20, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        add(OP_LW, 32'h24, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        add(OP_LW, 32'h28, 0, 4'hf, 0, 0, 0, 0, 0, F_NONE);
        // Masked vector loads with vstart and bank offset
        add(OP_VLE, 32'h40, 0, 4'b1101, 1, 2, 0, 0, 0, F_NONE);
        add(OP_VLE, 32'h50, 0, 4'hf, 0, 1, 0, 0, 0, F_NONE);
        // Strided stores, all-zero mask, read back
        add(OP_VSSE, 32'h80, 12, 4'b1011, 0, 0, 32'hc0de_0001, 0, 0, F_NONE);
        add(OP_VSSE, 32'h80, 12, 4'b0000, 0, 0, 32'hdead_beef, 0, 0, F_NONE);
        add(OP_VLSE, 32'h80, 12, 4'hf, 0, 3, 0, 0, 0, F_NONE);
        // Faults
        add(OP_LW, 32'h31, 0, 4'hf, 0, 0, 0, 0, 0, F_MAL_LOAD);
        add(OP_LH, 32'h33, 0, 4'hf, 0, 0, 0, 0, 0, F_MAL_LOAD);
        add(OP_VLE, 32'h42, 0, 4'hf, 0, 0, 0, 0, 0, F_MAL_LOAD);
        add(OP_VLE, 32'h60, 0, 4'hf, 0, 0, 0, 1, 32'h68, F_BUS);

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (tests[i]) begin
            @(negedge clk);
            cur     = tests[i];
            test_id = i;
            compute_expect(cur, i);
            req.op          = cur.op;
            req.rd          = 5'(i + 1);
            req.base        = cur.base;
            req.stride      = cur.stride;
            req.vstart      = cur.vstart;
            req.bank_offset = cur.boff;
            lane_mask       = cur.mask;
            for (int l = 0; l < LANES; l++) begin
                lane_store_data[l] = cur.sdata ^ (32'h1111_1111 * 32'(l));
            end
            n = 0;
            while (!ready) begin
                n = n + 1;
                if (n > 50) abort_run("timeout: stage never became ready");
                @(negedge clk);
            end
            req_valid = 1'b1;
            @(negedge clk);
            req_valid = 1'b0;
            n = 0;
            while (checked < i + 2) begin
                n = n + 1;
                if (n > 200) abort_run("timeout: operation never reported done");
                @(negedge clk);
            end
        end

        repeat (2) @(negedge clk);
        $display("tests checked %0d, errors %0d", checked, errors);
        if (errors == 0 && checked == tests.size() + 1) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
